//--- Bender.yml
package:
  name: miner_ctl

sources:
  # Package and interface first, then the modules that use them
  - logic/miner_ctl_pkg.sv
  - logic/reg_access_if.sv
  - logic/axil_req_decode.sv
  - logic/miner_reg_file.sv
  - logic/read_result_mux.sv
  - logic/miner_ctl_top.sv

  - target: test
    files:
      - verification/miner_ctl_tb.sv

//--- logic/axil_req_decode.sv
// AXI4-Lite slave front end, single-beat and full-word only.
// Turns channel handshakes into write and read pulses on reg_access_if.

`timescale 1ns/1ps

module axil_req_decode (
  input  logic                              clk_main_a0,
  input  logic                              rst_main_n_sync,
  input  logic                              awvalid,
  input  logic [miner_ctl_pkg::ADDR_W-1:0]  awaddr,
  output logic                              awready,
  input  logic                              wvalid,
  input  logic [miner_ctl_pkg::DATA_W-1:0]  wdata,
  output logic                              wready,
  output logic                              bvalid,
  output logic [miner_ctl_pkg::RESP_W-1:0]  bresp,
  input  logic                              bready,
  input  logic                              arvalid,
  input  logic [miner_ctl_pkg::ADDR_W-1:0]  araddr,
  output logic                              arready,
  output logic                              rvalid,
  output logic [miner_ctl_pkg::RESP_W-1:0]  rresp,
  input  logic                              rready,
  reg_access_if.req                         acc
);
  import miner_ctl_pkg::*;

  logic      wr_active;
  reg_addr_e wr_addr_q;
  logic      rd_pend;
  reg_addr_e rd_addr_q;

  // --------------------------------------------------------------------------
  // Write channels
  // --------------------------------------------------------------------------
  assign awready = ~wr_active;
  // Data only once per address, the response must drain first
  assign wready  = wr_active & wvalid & ~bvalid;
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      wr_addr_q <= reg_addr_e'(0);
      bvalid    <= 1'b0;
    end
    else
    begin
      if (awvalid && awready)
      begin
        wr_active <= 1'b1;
        wr_addr_q <= reg_addr_e'(awaddr);
      end
      else if (bvalid && bready)
        wr_active <= 1'b0;

      if (wready)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Read channels
  // --------------------------------------------------------------------------
  assign arready = ~rd_pend & ~rvalid;
  assign rresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend   <= 1'b0;
      rd_addr_q <= reg_addr_e'(0);
      rvalid    <= 1'b0;
    end
    else
    begin
      // Pending lasts exactly one cycle, it doubles as the rd_en pulse
      rd_pend <= arvalid & arready;
      if (arvalid && arready)
        rd_addr_q <= reg_addr_e'(araddr);

      if (rd_pend)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // Requests toward the register sinks
  assign acc.wr_en   = wready;
  assign acc.wr_addr = wr_addr_q;
  assign acc.wr_data = wdata;
  assign acc.rd_en   = rd_pend;
  assign acc.rd_addr = rd_addr_q;

  // One data beat per accepted address
  a_wready_in_write: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |=> !wready until (awvalid && awready));
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid);

endmodule

//--- logic/miner_ctl_pkg.sv
// Shared widths, register map and constants for the miner control block.
// Imported by every RTL module and by the testbench.

package miner_ctl_pkg;

  // --------------------------------------------------------------------------
  // Bus and field widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int RESP_W   = 2;
  localparam int VLED_W   = 16;
  localparam int STATUS_W = 2;

  // Hash words exposed by the miner core
  localparam int BLK_CNT    = 12;
  localparam int HASH_SEL_W = $clog2(BLK_CNT);

  // --------------------------------------------------------------------------
  // Fixed return values
  // --------------------------------------------------------------------------
  // Returned for any address outside the map
  localparam logic [DATA_W-1:0] UNIMPL_VALUE = 32'hdead_beef;

  // Every access completes as OKAY
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------
  typedef enum logic [ADDR_W-1:0] {
    // Read/write scratch, reads back byte-swapped
    REG_SCRATCH      = 32'h0000_0500,
    // Read-only status and results
    REG_VLED         = 32'h0000_0504,
    REG_STATUS       = 32'h0000_0508,
    REG_NONCE        = 32'h0000_050C,
    REG_HEAVYHASH    = 32'h0000_0510,
    // Write-only miner control
    REG_BLOCK_HEADER = 32'h0000_0520,
    REG_MATRIX       = 32'h0000_0524,
    REG_TARGET       = 32'h0000_0528,
    REG_NONCE_SIZE   = 32'h0000_052C,
    REG_START        = 32'h0000_0530,
    REG_STOP         = 32'h0000_0534,
    REG_HASH_SEL     = 32'h0000_0538
  } reg_addr_e;

endpackage

//--- logic/miner_ctl_top.sv
// Top level of the miner register block, AXI4-Lite slave with plain ports.
// Connects the front end, register file and read mux over reg_access_if.

`timescale 1ns/1ps

module miner_ctl_top (
  input  logic                                  clk_main_a0,
  input  logic                                  rst_main_n_sync,
  // AXI4-Lite slave
  input  logic                                  awvalid,
  input  logic [miner_ctl_pkg::ADDR_W-1:0]      awaddr,
  output logic                                  awready,
  input  logic                                  wvalid,
  input  logic [miner_ctl_pkg::DATA_W-1:0]      wdata,
  output logic                                  wready,
  output logic                                  bvalid,
  output logic [miner_ctl_pkg::RESP_W-1:0]      bresp,
  input  logic                                  bready,
  input  logic                                  arvalid,
  input  logic [miner_ctl_pkg::ADDR_W-1:0]      araddr,
  output logic                                  arready,
  output logic                                  rvalid,
  output logic [miner_ctl_pkg::DATA_W-1:0]      rdata,
  output logic [miner_ctl_pkg::RESP_W-1:0]      rresp,
  input  logic                                  rready,
  // Virtual DIP switches and LEDs
  input  logic [miner_ctl_pkg::VLED_W-1:0]      vdip,
  output logic [miner_ctl_pkg::VLED_W-1:0]      vled,
  // Miner core control
  output logic [miner_ctl_pkg::DATA_W-1:0]      block_header,
  output logic                                  block_header_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      matrix_in,
  output logic                                  matrix_fifo_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      target,
  output logic                                  target_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      nonce_size,
  output logic                                  start,
  output logic                                  stop,
  output logic [miner_ctl_pkg::HASH_SEL_W-1:0]  hash_select,
  // Miner core results
  input  logic [miner_ctl_pkg::STATUS_W-1:0]    status,
  input  logic [miner_ctl_pkg::DATA_W-1:0]      nonce,
  input  logic [miner_ctl_pkg::DATA_W-1:0]      heavyhash,
  output logic                                  hash_re
);
  import miner_ctl_pkg::*;

  logic [DATA_W-1:0] scratch;
  logic [VLED_W-1:0] vled_shadow;

  reg_access_if acc_if (
    .clk_main_a0 (clk_main_a0)
  );

  // --------------------------------------------------------------------------
  // Bus front end
  // --------------------------------------------------------------------------
  axil_req_decode decode_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rresp           (rresp),
    .rready          (rready),
    .acc             (acc_if.req)
  );

  // --------------------------------------------------------------------------
  // Registers and read data
  // --------------------------------------------------------------------------
  miner_reg_file reg_file_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .acc             (acc_if.wr_sink),
    .vdip            (vdip),
    .vled            (vled),
    .vled_shadow     (vled_shadow),
    .scratch         (scratch),
    .block_header    (block_header),
    .block_header_we (block_header_we),
    .matrix_in       (matrix_in),
    .matrix_fifo_we  (matrix_fifo_we),
    .target          (target),
    .target_we       (target_we),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select)
  );

  read_result_mux result_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .acc             (acc_if.rd_sink),
    .scratch         (scratch),
    .vled_shadow     (vled_shadow),
    .status          (status),
    .nonce           (nonce),
    .heavyhash       (heavyhash),
    .rdata           (rdata),
    .hash_re         (hash_re)
  );

endmodule

//--- logic/miner_reg_file.sv
// Writable registers of the miner block, control pulses and the LED path.
// Samples decoded writes from reg_access_if, one edge after the data beat.

`timescale 1ns/1ps

module miner_reg_file (
  input  logic                                  clk_main_a0,
  input  logic                                  rst_main_n_sync,
  reg_access_if.wr_sink                         acc,
  input  logic [miner_ctl_pkg::VLED_W-1:0]      vdip,
  output logic [miner_ctl_pkg::VLED_W-1:0]      vled,
  output logic [miner_ctl_pkg::VLED_W-1:0]      vled_shadow,
  output logic [miner_ctl_pkg::DATA_W-1:0]      scratch,
  output logic [miner_ctl_pkg::DATA_W-1:0]      block_header,
  output logic                                  block_header_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      matrix_in,
  output logic                                  matrix_fifo_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      target,
  output logic                                  target_we,
  output logic [miner_ctl_pkg::DATA_W-1:0]      nonce_size,
  output logic                                  start,
  output logic                                  stop,
  output logic [miner_ctl_pkg::HASH_SEL_W-1:0]  hash_select
);
  import miner_ctl_pkg::*;

  logic [VLED_W-1:0] vdip_q1;
  logic [VLED_W-1:0] vdip_q2;

  // --------------------------------------------------------------------------
  // Control and data registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      scratch         <= '0;
      block_header    <= '0;
      matrix_in       <= '0;
      target          <= '0;
      nonce_size      <= '0;
      hash_select     <= '0;
      block_header_we <= 1'b0;
      matrix_fifo_we  <= 1'b0;
      target_we       <= 1'b0;
      start           <= 1'b0;
      stop            <= 1'b0;
    end
    else
    begin
      // Pulses drop unless refreshed by a write this cycle
      block_header_we <= 1'b0;
      matrix_fifo_we  <= 1'b0;
      target_we       <= 1'b0;
      start           <= 1'b0;
      stop            <= 1'b0;

      if (acc.wr_en)
      begin
        case (acc.wr_addr)
          REG_SCRATCH:
            scratch <= acc.wr_data;
          REG_BLOCK_HEADER:
          begin
            block_header    <= acc.wr_data;
            block_header_we <= 1'b1;
          end
          REG_MATRIX:
          begin
            matrix_in      <= acc.wr_data;
            matrix_fifo_we <= 1'b1;
          end
          REG_TARGET:
          begin
            target    <= acc.wr_data;
            target_we <= 1'b1;
          end
          REG_NONCE_SIZE:
            nonce_size <= acc.wr_data;
          REG_START:
            start <= 1'b1;
          REG_STOP:
            stop <= 1'b1;
          REG_HASH_SEL:
            hash_select <= acc.wr_data[HASH_SEL_W-1:0];
          // Read-only and unmapped addresses drop the write
          default:
            ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Virtual LEDs
  // --------------------------------------------------------------------------
  // DIP switches arrive asynchronous, two flops before use
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      vled_shadow <= '0;
      vled        <= '0;
    end
    else
    begin
      vdip_q1     <= vdip;
      vdip_q2     <= vdip_q1;
      vled_shadow <= scratch[VLED_W-1:0];
      // Switch off any LED whose DIP is low
      vled        <= vled_shadow & vdip_q2;
    end
  end

  a_pulse_onehot: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $onehot0({block_header_we, matrix_fifo_we, target_we, start, stop}));

endmodule

//--- logic/read_result_mux.sv
// Registered read data for the AXI-Lite R channel.
// Loads on rd_en so the value lines up with the rvalid rise.

`timescale 1ns/1ps

module read_result_mux (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  reg_access_if.rd_sink                       acc,
  input  logic [miner_ctl_pkg::DATA_W-1:0]    scratch,
  input  logic [miner_ctl_pkg::VLED_W-1:0]    vled_shadow,
  input  logic [miner_ctl_pkg::STATUS_W-1:0]  status,
  input  logic [miner_ctl_pkg::DATA_W-1:0]    nonce,
  input  logic [miner_ctl_pkg::DATA_W-1:0]    heavyhash,
  output logic [miner_ctl_pkg::DATA_W-1:0]    rdata,
  output logic                                hash_re
);
  import miner_ctl_pkg::*;

  logic [DATA_W-1:0] scratch_swapped;

  // Scratch reads back with its bytes reversed
  assign scratch_swapped = {scratch[7:0], scratch[15:8], scratch[23:16], scratch[31:24]};

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rdata   <= '0;
      hash_re <= 1'b0;
    end
    else
    begin
      // Hash FIFO pops once per heavyhash read
      hash_re <= acc.rd_en && (acc.rd_addr == REG_HEAVYHASH);

      if (acc.rd_en)
      begin
        case (acc.rd_addr)
          REG_SCRATCH:
            rdata <= scratch_swapped;
          REG_VLED:
            rdata <= {{(DATA_W - VLED_W){1'b0}}, vled_shadow};
          REG_STATUS:
            rdata <= {{(DATA_W - STATUS_W){1'b0}}, status};
          REG_NONCE:
            rdata <= nonce;
          REG_HEAVYHASH:
            rdata <= heavyhash;
          // Write-only registers read as unmapped too
          default:
            rdata <= UNIMPL_VALUE;
        endcase
      end
    end
  end

endmodule

//--- logic/reg_access_if.sv
// Decoded register access between the AXI-Lite front end and its sinks.
// One write and one read request per cycle at most, sinks never stall.

`timescale 1ns/1ps

interface reg_access_if (
  input logic clk_main_a0
);
  import miner_ctl_pkg::*;

  // Write request, valid in the cycle of the data handshake
  logic              wr_en;
  reg_addr_e         wr_addr;
  logic [DATA_W-1:0] wr_data;

  // Read request, one cycle after the address handshake
  logic              rd_en;
  reg_addr_e         rd_addr;

  modport req (
    input  clk_main_a0,
    output wr_en, wr_addr, wr_data, rd_en, rd_addr
  );

  modport wr_sink (
    input clk_main_a0, wr_en, wr_addr, wr_data
  );

  modport rd_sink (
    input clk_main_a0, rd_en, rd_addr
  );

endinterface

//--- miner_ctl_top.f
logic/miner_ctl_pkg.sv
logic/reg_access_if.sv
logic/axil_req_decode.sv
logic/miner_reg_file.sv
logic/read_result_mux.sv
logic/miner_ctl_top.sv
verification/miner_ctl_tb.sv

//--- verification/miner_ctl_tb.sv
// Self-checking testbench for the miner register block.
// Drives random AXI4-Lite traffic and checks responses against a register model.

`timescale 1ns/1ps

module miner_ctl_tb;
  import miner_ctl_pkg::*;

  localparam int ROUNDS = 8;
  // Transaction budget times worst-case cycles per transaction with stalls
  localparam int TXN_BUDGET     = 1000;
  localparam int CYCLES_PER_TXN = 20;
  localparam int TIMEOUT_CYCLES = TXN_BUDGET * CYCLES_PER_TXN;

  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  logic                  awvalid;
  logic [ADDR_W-1:0]     awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [DATA_W-1:0]     wdata;
  logic                  wready;
  logic                  bvalid;
  logic [RESP_W-1:0]     bresp;
  logic                  bready;
  logic                  arvalid;
  logic [ADDR_W-1:0]     araddr;
  logic                  arready;
  logic                  rvalid;
  logic [DATA_W-1:0]     rdata;
  logic [RESP_W-1:0]     rresp;
  logic                  rready;
  logic [VLED_W-1:0]     vdip;
  logic [VLED_W-1:0]     vled;
  logic [DATA_W-1:0]     block_header;
  logic                  block_header_we;
  logic [DATA_W-1:0]     matrix_in;
  logic                  matrix_fifo_we;
  logic [DATA_W-1:0]     target;
  logic                  target_we;
  logic [DATA_W-1:0]     nonce_size;
  logic                  start;
  logic                  stop;
  logic [HASH_SEL_W-1:0] hash_select;
  logic [STATUS_W-1:0]   status;
  logic [DATA_W-1:0]     nonce;
  logic [DATA_W-1:0]     heavyhash;
  logic                  hash_re;

  // Register model
  logic [DATA_W-1:0]     m_scratch;
  logic [DATA_W-1:0]     m_header;
  logic [DATA_W-1:0]     m_matrix;
  logic [DATA_W-1:0]     m_target;
  logic [DATA_W-1:0]     m_nonce_size;
  logic [HASH_SEL_W-1:0] m_hash_sel;
  logic [VLED_W-1:0]     m_vdip;

  // Pulse and response monitors
  int                    hdr_cnt;
  int                    mtx_cnt;
  int                    tgt_cnt;
  int                    start_cnt;
  int                    stop_cnt;
  int                    hash_re_cnt;
  int                    b_cnt;
  int                    r_cnt;
  logic [DATA_W-1:0]     hdr_seen;
  logic [DATA_W-1:0]     mtx_seen;
  logic [DATA_W-1:0]     tgt_seen;

  int                    n_checks = 0;
  int                    n_errors = 0;
  int                    test_start = 0;
  int                    cycle_count = 0;

  miner_ctl_top dut_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled),
    .block_header    (block_header),
    .block_header_we (block_header_we),
    .matrix_in       (matrix_in),
    .matrix_fifo_we  (matrix_fifo_we),
    .target          (target),
    .target_we       (target_we),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select),
    .status          (status),
    .nonce           (nonce),
    .heavyhash       (heavyhash),
    .hash_re         (hash_re)
  );

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  always @(posedge clk_main_a0)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Count pulses and completed responses, values as held before the edge
  always @(posedge clk_main_a0)
  begin
    if (block_header_we)
    begin
      hdr_cnt++;
      hdr_seen = block_header;
    end
    if (matrix_fifo_we)
    begin
      mtx_cnt++;
      mtx_seen = matrix_in;
    end
    if (target_we)
    begin
      tgt_cnt++;
      tgt_seen = target;
    end
    if (start)
      start_cnt++;
    if (stop)
      stop_cnt++;
    if (hash_re)
      hash_re_cnt++;
    if (bvalid && bready)
      b_cnt++;
    if (rvalid && rready)
      r_cnt++;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, n_errors - test_start);
    test_start = n_errors;
  endtask

  // Lowest byte goes to the top, byte by byte
  function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    for (int b = 0; b < DATA_W / 8; b++)
      r[8*b +: 8] = d[DATA_W - 8 - 8*b +: 8];
    return r;
  endfunction

  function automatic bit is_mapped(input logic [ADDR_W-1:0] a);
    case (a)
      REG_SCRATCH, REG_VLED, REG_STATUS, REG_NONCE, REG_HEAVYHASH,
      REG_BLOCK_HEADER, REG_MATRIX, REG_TARGET, REG_NONCE_SIZE,
      REG_START, REG_STOP, REG_HASH_SEL:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  task automatic clear_counts();
    hdr_cnt     = 0;
    mtx_cnt     = 0;
    tgt_cnt     = 0;
    start_cnt   = 0;
    stop_cnt    = 0;
    hash_re_cnt = 0;
  endtask

  // Full AXI-Lite write, bready held off for 0 to 5 cycles
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int delay;
    delay = $urandom_range(5);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    while (!awready)
      @(negedge clk_main_a0);
    // No data beat before the address is taken
    compare("wready", wready, 0);
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    while (!wready)
      @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    compare("bvalid", bvalid, 1);
    compare("bresp", bresp, RESP_OKAY);
    repeat (delay)
    begin
      @(negedge clk_main_a0);
      compare("bvalid", bvalid, 1);
      compare("awready", awready, 0);
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
    compare("bvalid", bvalid, 0);
  endtask

  // Full AXI-Lite read, rready held off for 0 to 5 cycles
  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int delay;
    int latency;
    delay = $urandom_range(5);
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready)
      @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    latency = 1;
    while (!rvalid)
    begin
      @(negedge clk_main_a0);
      latency++;
    end
    compare("rvalid latency", latency, 2);
    compare("rresp", rresp, RESP_OKAY);
    data = rdata;
    repeat (delay)
    begin
      @(negedge clk_main_a0);
      compare("rvalid", rvalid, 1);
      compare("rdata", rdata, data);
      compare("arready", arready, 0);
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
    compare("rvalid", rvalid, 0);
  endtask

  // Write and check pulse counts, exp is {header, matrix, target, start, stop}
  task automatic pulse_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [4:0] exp);
    clear_counts();
    write_reg(addr, data);
    compare("block_header_we pulses", hdr_cnt, exp[4]);
    compare("matrix_fifo_we pulses", mtx_cnt, exp[3]);
    compare("target_we pulses", tgt_cnt, exp[2]);
    compare("start pulses", start_cnt, exp[1]);
    compare("stop pulses", stop_cnt, exp[0]);
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] value;
    logic [ADDR_W-1:0] addr;
    int                n_wr;
    int                n_rd;

    void'($urandom(32'h51a8bc57));
    rst_main_n_sync = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    vdip      = '0;
    status    = '0;
    nonce     = '0;
    heavyhash = '0;
    m_scratch    = '0;
    m_header     = '0;
    m_matrix     = '0;
    m_target     = '0;
    m_nonce_size = '0;
    m_hash_sel   = '0;
    m_vdip       = '0;
    clear_counts();
    b_cnt = 0;
    r_cnt = 0;
    repeat (10) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    compare("awready", awready, 1);
    compare("arready", arready, 1);
    compare("bvalid", bvalid, 0);
    compare("rvalid", rvalid, 0);
    compare("vled", vled, 0);
    end_test("Reset values");

    for (int i = 0; i < ROUNDS; i++)
    begin
      value = $urandom;
      write_reg(REG_SCRATCH, value);
      m_scratch = value;
      read_reg(REG_SCRATCH, data);
      compare("rdata", data, byte_swap(m_scratch));
    end
    end_test("Test 1 scratch byte swap");

    for (int i = 0; i < ROUNDS; i++)
    begin
      value = $urandom;
      write_reg(REG_SCRATCH, value);
      m_scratch = value;
      vdip      = $urandom;
      m_vdip    = vdip;
      // Shadow plus DIP synchronizer settle within three edges
      repeat (5) @(negedge clk_main_a0);
      compare("vled", vled, m_scratch[VLED_W-1:0] & m_vdip);
      read_reg(REG_VLED, data);
      compare("rdata", data, {{(DATA_W - VLED_W){1'b0}}, m_scratch[VLED_W-1:0]});
    end
    end_test("Test 2 virtual LEDs");

    for (int i = 0; i < ROUNDS; i++)
    begin
      m_header = $urandom;
      pulse_write(REG_BLOCK_HEADER, m_header, 5'b10000);
      compare("block_header", hdr_seen, m_header);
      m_matrix = $urandom;
      pulse_write(REG_MATRIX, m_matrix, 5'b01000);
      compare("matrix_in", mtx_seen, m_matrix);
      m_target = $urandom;
      pulse_write(REG_TARGET, m_target, 5'b00100);
      compare("target", tgt_seen, m_target);
      pulse_write(REG_START, $urandom, 5'b00010);
      pulse_write(REG_STOP, $urandom, 5'b00001);
      m_nonce_size = $urandom;
      pulse_write(REG_NONCE_SIZE, m_nonce_size, 5'b00000);
      value      = $urandom;
      m_hash_sel = value[HASH_SEL_W-1:0];
      pulse_write(REG_HASH_SEL, value, 5'b00000);
      // Data ports hold after the pulses are gone
      compare("block_header", block_header, m_header);
      compare("matrix_in", matrix_in, m_matrix);
      compare("target", target, m_target);
      compare("nonce_size", nonce_size, m_nonce_size);
      compare("hash_select", hash_select, m_hash_sel);
    end
    end_test("Test 3 miner control writes");

    for (int i = 0; i < ROUNDS; i++)
    begin
      @(negedge clk_main_a0);
      status    = $urandom;
      nonce     = $urandom;
      heavyhash = $urandom;
      clear_counts();
      read_reg(REG_STATUS, data);
      compare("rdata", data, {{(DATA_W - STATUS_W){1'b0}}, status});
      read_reg(REG_NONCE, data);
      compare("rdata", data, nonce);
      compare("hash_re pulses", hash_re_cnt, 0);
      read_reg(REG_HEAVYHASH, data);
      compare("rdata", data, heavyhash);
      compare("hash_re pulses", hash_re_cnt, 1);
    end
    end_test("Test 4 miner status reads");

    for (int i = 0; i < ROUNDS; i++)
    begin
      // Half near the register map, half anywhere
      do
        addr = (i % 2) ? $urandom : 32'h0000_0500 + ($urandom_range(63) << 2);
      while (is_mapped(addr));
      clear_counts();
      read_reg(addr, data);
      compare("rdata", data, UNIMPL_VALUE);
      compare("hash_re pulses", hash_re_cnt, 0);
      pulse_write(addr, $urandom, 5'b00000);
      compare("block_header", block_header, m_header);
      compare("matrix_in", matrix_in, m_matrix);
      compare("target", target, m_target);
      compare("nonce_size", nonce_size, m_nonce_size);
      compare("hash_select", hash_select, m_hash_sel);
      compare("vled", vled, m_scratch[VLED_W-1:0] & m_vdip);
      read_reg(REG_SCRATCH, data);
      compare("rdata", data, byte_swap(m_scratch));
    end
    end_test("Test 5 unmapped addresses");

    b_cnt = 0;
    r_cnt = 0;
    n_wr  = 0;
    n_rd  = 0;
    for (int i = 0; i < 4 * ROUNDS; i++)
    begin
      if ($urandom_range(1))
      begin
        value = $urandom;
        write_reg(REG_SCRATCH, value);
        m_scratch = value;
        n_wr++;
      end
      else
      begin
        read_reg(REG_SCRATCH, data);
        compare("rdata", data, byte_swap(m_scratch));
        n_rd++;
      end
    end
    repeat (5) @(negedge clk_main_a0);
    compare("bvalid", bvalid, 0);
    compare("rvalid", rvalid, 0);
    compare("write responses", b_cnt, n_wr);
    compare("read responses", r_cnt, n_rd);
    end_test("Test 6 response stalls");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
